//--- leaf_i7o3.f
+incdir+logic
logic/leaf_pkg.sv
logic/packet_decoder.sv
logic/user_kernel.sv
logic/packetizer.sv
logic/leaf_i7o3.sv
bench/leaf_clock_gen.sv
bench/leaf_i7o3_tb.sv

//--- Bender.yml
package:
  name: leaf_i7o3

sources:
  - include_dirs:
      - logic
    files:
      - logic/leaf_pkg.sv
      - logic/packet_decoder.sv
      - logic/user_kernel.sv
      - logic/packetizer.sv
      - logic/leaf_i7o3.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/leaf_clock_gen.sv
      - bench/leaf_i7o3_tb.sv

//--- bench/leaf_i7o3_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_settings.svh"

module leaf_i7o3_tb
    import leaf_pkg::*;
;

    localparam int max_cycles = 2000;

    logic        clk;
    logic        rst_n;
    bft_packet_u din_leaf_bft2interface;
    bft_packet_u dout_leaf_interface2bft;
    logic        resend;
    logic        ap_start;
    logic        overflow;

    // expected packets per lane, and the lane order the round-robin should follow.
    bft_packet_u exp_q [`LEAF_NUM_OUT_PORTS][$];
    int          lane_order [$];
    logic        drop_sent = 1'b0;
    logic        overflow_sticky = 1'b0;
    int          cycle_count = 0;

    leaf_clock_gen leaf_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    leaf_i7o3 leaf_i7o3_inst (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start),
        .overflow                (overflow)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic bft_packet_u data_packet(input logic [`LEAF_NUM_LEAF_BITS-1:0] leaf,
                                                input logic [`LEAF_NUM_PORT_BITS-1:0] port,
                                                input logic [`LEAF_PAYLOAD_BITS-1:0] payload);
        bft_packet_u pkt;
        pkt                = '0;
        pkt.data.valid     = 1'b1;
        pkt.data.dest_leaf = leaf;
        pkt.data.dest_port = port;
        pkt.data.addr      = '0;
        pkt.data.payload   = payload;
        return pkt;
    endfunction

    // configuration goes to port zero and names out_port 1..3.
    function automatic bft_packet_u route_packet(input logic [`LEAF_NUM_PORT_BITS-1:0] out_port,
                                                 input logic [`LEAF_NUM_LEAF_BITS-1:0] leaf,
                                                 input logic [`LEAF_NUM_PORT_BITS-1:0] port);
        bft_packet_u pkt;
        pkt                = '0;
        pkt.cfg.valid      = 1'b1;
        pkt.cfg.dest_port  = '0;
        pkt.cfg.out_port   = out_port;
        pkt.cfg.route_leaf = leaf;
        pkt.cfg.route_port = port;
        return pkt;
    endfunction

    task automatic send_packet(input bft_packet_u pkt);
        @(posedge clk);
        din_leaf_bft2interface <= pkt;
        @(posedge clk);
        din_leaf_bft2interface <= '0;
    endtask

    task automatic expect_packet(input int lane, input bft_packet_u pkt);
        exp_q[lane].push_back(pkt);
        lane_order.push_back(lane);
    endtask

    task automatic wait_drained();
        while (lane_order.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            fail_run("Timeout: the run went past 2000 clock cycles without finishing.");
        end
    end

    resend_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        resend |-> dout_leaf_interface2bft == '0)
        else fail_run($sformatf("** Error at %0t: dout_leaf_interface2bft expected %h, got %h",
                                $time, 49'h0, $sampled(dout_leaf_interface2bft)));

    // outputs settle well before the falling edge.
    always @(negedge clk) begin : output_monitor
        bft_packet_u want;
        int          lane;
        if (rst_n) begin
            if (dout_leaf_interface2bft.data.valid) begin
                if (lane_order.size() == 0) begin
                    fail_run("An output packet appeared where none was expected.");
                end else begin
                    lane = lane_order.pop_front();
                    want = exp_q[lane].pop_front();
                    dout_match: assert (dout_leaf_interface2bft === want)
                        else fail_run($sformatf(
                            "** Error at %0t: dout_leaf_interface2bft expected %h, got %h",
                            $time, want, dout_leaf_interface2bft));
                end
            end else begin
                dout_idle: assert (dout_leaf_interface2bft === '0)
                    else fail_run($sformatf(
                        "** Error at %0t: dout_leaf_interface2bft expected %h, got %h",
                        $time, 49'h0, dout_leaf_interface2bft));
            end
            if (overflow_sticky) begin
                overflow_held: assert (overflow === 1'b1)
                    else fail_run($sformatf("** Error at %0t: overflow expected 1, got %b",
                                            $time, overflow));
            end else if (!drop_sent) begin
                overflow_low: assert (overflow === 1'b0)
                    else fail_run($sformatf("** Error at %0t: overflow expected 0, got %b",
                                            $time, overflow));
            end
        end
    end

    initial begin
        logic [`LEAF_PAYLOAD_BITS-1:0]  word [`LEAF_NUM_IN_PORTS];
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf_a;
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf_b;
        logic [`LEAF_NUM_PORT_BITS-1:0] port_a;
        logic [`LEAF_NUM_PORT_BITS-1:0] port_b;
        logic [`LEAF_PAYLOAD_BITS-1:0]  first_word;
        logic [`LEAF_PAYLOAD_BITS-1:0]  lost_word;
        logic [`LEAF_PAYLOAD_BITS-1:0]  partner_word;
        void'($urandom(22519));
        din_leaf_bft2interface = '0;
        resend                 = 1'b0;
        ap_start               = 1'b0;
        @(posedge rst_n);
        repeat (4) @(posedge clk);

        // routes for lanes 1 and 2; lane 3 keeps its reset route.
        leaf_a = `LEAF_NUM_LEAF_BITS'($urandom);
        leaf_b = `LEAF_NUM_LEAF_BITS'($urandom);
        port_a = `LEAF_NUM_PORT_BITS'($urandom_range(15, 1));
        port_b = `LEAF_NUM_PORT_BITS'($urandom_range(15, 1));
        send_packet(route_packet(4'd1, leaf_a, port_a));
        send_packet(route_packet(4'd2, leaf_b, port_b));

        for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
            word[p] = $urandom;
            send_packet(data_packet('0, `LEAF_NUM_PORT_BITS'(p + 1), word[p]));
        end
        // nothing may leave before ap_start.
        repeat (20) @(posedge clk);

        // after reset the search starts at lane 1.
        expect_packet(0, data_packet(leaf_a, port_a, word[0] + word[1]));
        expect_packet(1, data_packet(leaf_b, port_b, word[2] + word[3]));
        expect_packet(2, data_packet('0, '0, word[4] + word[5] + word[6]));
        @(posedge clk);
        ap_start <= 1'b1;
        @(posedge clk);
        ap_start <= 1'b0;
        wait_drained();

        // a second word on in-port 1 is lost while in-port 2 is still empty.
        first_word   = $urandom;
        lost_word    = $urandom;
        partner_word = $urandom;
        send_packet(data_packet('0, 4'd1, first_word));
        drop_sent = 1'b1;
        send_packet(data_packet('0, 4'd1, lost_word));
        @(negedge clk);
        overflow_set: assert (overflow === 1'b1)
            else fail_run($sformatf("** Error at %0t: overflow expected 1, got %b",
                                    $time, overflow));
        overflow_sticky = 1'b1;
        expect_packet(0, data_packet(leaf_a, port_a, first_word + partner_word));
        send_packet(data_packet('0, 4'd2, partner_word));
        wait_drained();

        // all three lanes fill while resend holds the output.
        @(posedge clk);
        resend <= 1'b1;
        for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
            word[p] = $urandom;
            send_packet(data_packet('0, `LEAF_NUM_PORT_BITS'(p + 1), word[p]));
        end
        repeat (20) @(posedge clk);
        // lane 1 went last, so the search starts at lane 2 and wraps round to lane 1.
        expect_packet(1, data_packet(leaf_b, port_b, word[2] + word[3]));
        expect_packet(2, data_packet('0, '0, word[4] + word[5] + word[6]));
        expect_packet(0, data_packet(leaf_a, port_a, word[0] + word[1]));
        @(posedge clk);
        resend <= 1'b0;
        wait_drained();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/leaf_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period.
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset is held low over the first two rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/leaf_i7o3.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_settings.svh"

module leaf_i7o3
    import leaf_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  bft_packet_u din_leaf_bft2interface,
    output bft_packet_u dout_leaf_interface2bft,
    input  logic        resend,
    input  logic        ap_start,
    output logic        overflow
);

    port_word_t                     in_words [`LEAF_NUM_IN_PORTS];
    logic [`LEAF_NUM_IN_PORTS-1:0]  in_acks;
    port_word_t                     sums [`LEAF_NUM_OUT_PORTS];
    logic [`LEAF_NUM_OUT_PORTS-1:0] sum_acks;
    route_write_t                   route_wr;

    // decode stage.
    packet_decoder packet_decoder_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din_leaf_bft2interface),
        .in_words (in_words),
        .in_acks  (in_acks),
        .route_wr (route_wr),
        .overflow (overflow)
    );

    // the three adder lanes.
    user_kernel user_kernel_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ap_start (ap_start),
        .in_words (in_words),
        .in_acks  (in_acks),
        .sums     (sums),
        .sum_acks (sum_acks)
    );

    // sums go back into the tree here.
    packetizer packetizer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .resend   (resend),
        .route_wr (route_wr),
        .sums     (sums),
        .sum_acks (sum_acks),
        .dout     (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

//--- logic/packetizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_settings.svh"

module packetizer
    import leaf_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         resend,
    input  route_write_t route_wr,
    input  port_word_t   sums [`LEAF_NUM_OUT_PORTS],
    output logic [`LEAF_NUM_OUT_PORTS-1:0] sum_acks,
    output bft_packet_u  dout
);

    logic [`LEAF_NUM_LEAF_BITS-1:0] route_leaf [`LEAF_NUM_OUT_PORTS];
    logic [`LEAF_NUM_PORT_BITS-1:0] route_port [`LEAF_NUM_OUT_PORTS];
    logic [1:0]                     last_lane;
    logic [1:0]                     pick;
    logic                           any_vld;
    logic                           grant;
    bft_packet_u                    tx_pkt;
    bft_packet_u                    dout_q;

    // search starts one past the lane served last.
    always_comb begin
        int cand;
        any_vld = 1'b0;
        pick    = last_lane;
        for (int off = 1; off <= `LEAF_NUM_OUT_PORTS; off++) begin
            cand = (int'(last_lane) + off) % `LEAF_NUM_OUT_PORTS;
            if (!any_vld && sums[cand].vld) begin
                any_vld = 1'b1;
                pick    = 2'(cand);
            end
        end
    end

    assign grant = any_vld && !resend;

    always_comb begin
        sum_acks = '0;
        if (grant) begin
            sum_acks[pick] = 1'b1;
        end
    end

    always_comb begin
        tx_pkt                = '0;
        tx_pkt.data.valid     = 1'b1;
        tx_pkt.data.dest_leaf = route_leaf[pick];
        tx_pkt.data.dest_port = route_port[pick];
        tx_pkt.data.addr      = '0;
        tx_pkt.data.payload   = sums[pick].data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_lane <= 2'(`LEAF_NUM_OUT_PORTS - 1);
            dout_q    <= '0;
            for (int k = 0; k < `LEAF_NUM_OUT_PORTS; k++) begin
                route_leaf[k] <= '0;
                route_port[k] <= '0;
            end
        end else begin
            if (route_wr.en && route_wr.out_port != '0) begin
                route_leaf[route_wr.out_port - 1'b1] <= route_wr.leaf;
                route_port[route_wr.out_port - 1'b1] <= route_wr.port;
            end
            // a packet built just before resend rose waits here until it falls.
            if (!resend) begin
                if (grant) begin
                    dout_q    <= tx_pkt;
                    last_lane <= pick;
                end else begin
                    dout_q    <= '0;
                end
            end
        end
    end

    assign dout = resend ? '0 : dout_q;

endmodule

`default_nettype wire

//--- logic/user_kernel.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_settings.svh"

module user_kernel
    import leaf_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ap_start,
    input  port_word_t in_words [`LEAF_NUM_IN_PORTS],
    output logic [`LEAF_NUM_IN_PORTS-1:0] in_acks,
    output port_word_t sums [`LEAF_NUM_OUT_PORTS],
    input  logic [`LEAF_NUM_OUT_PORTS-1:0] sum_acks
);

    // in-ports feeding each lane: 1+2, 3+4 and 5+6+7.
    localparam logic [`LEAF_NUM_OUT_PORTS-1:0][`LEAF_NUM_IN_PORTS-1:0] lane_mask = {
        7'b111_0000,
        7'b000_1100,
        7'b000_0011
    };

    logic                                              started;
    logic [`LEAF_NUM_OUT_PORTS-1:0]                    lane_ready;
    logic [`LEAF_NUM_OUT_PORTS-1:0]                    lane_go;
    logic [`LEAF_NUM_OUT_PORTS-1:0][`LEAF_PAYLOAD_BITS-1:0] lane_sum;

    always_comb begin
        for (int k = 0; k < `LEAF_NUM_OUT_PORTS; k++) begin
            lane_ready[k] = 1'b1;
            lane_sum[k]   = '0;
            for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
                if (lane_mask[k][p]) begin
                    lane_ready[k] = lane_ready[k] && in_words[p].vld;
                    // the adder wraps modulo 2^32.
                    lane_sum[k]   = lane_sum[k] + in_words[p].data;
                end
            end
            lane_go[k] = started && lane_ready[k] && !sums[k].vld;
        end
    end

    // every port of a firing lane is acked in the same cycle.
    always_comb begin
        in_acks = '0;
        for (int k = 0; k < `LEAF_NUM_OUT_PORTS; k++) begin
            if (lane_go[k]) begin
                in_acks = in_acks | lane_mask[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `LEAF_NUM_OUT_PORTS; k++) begin
                sums[k].vld <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `LEAF_NUM_OUT_PORTS; k++) begin
                if (lane_go[k]) begin
                    sums[k].vld  <= 1'b1;
                    sums[k].data <= lane_sum[k];
                end else if (sum_acks[k]) begin
                    sums[k].vld  <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/packet_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "leaf_settings.svh"

module packet_decoder
    import leaf_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  bft_packet_u  din,
    output port_word_t   in_words [`LEAF_NUM_IN_PORTS],
    input  logic [`LEAF_NUM_IN_PORTS-1:0] in_acks,
    output route_write_t route_wr,
    output logic         overflow
);

    logic                          pkt_is_cfg;
    logic                          cfg_target_ok;
    logic [`LEAF_NUM_IN_PORTS-1:0] port_hit;
    logic [`LEAF_NUM_IN_PORTS-1:0] port_full;

    // dest_port zero marks a routing update, anything else picks an in-port.
    assign pkt_is_cfg    = din.data.valid && (din.data.dest_port == '0);
    assign cfg_target_ok = (din.cfg.out_port != '0) &&
                           (din.cfg.out_port <= `LEAF_NUM_OUT_PORTS);

    always_comb begin
        for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
            port_hit[p]  = din.data.valid && (din.data.dest_port == p + 1);
            // a word being acked this cycle frees its slot for the new packet.
            port_full[p] = in_words[p].vld && !in_acks[p];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            route_wr <= '0;
            overflow <= 1'b0;
            for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
                in_words[p].vld <= 1'b0;
            end
        end else begin
            route_wr <= '0;
            if (pkt_is_cfg && cfg_target_ok) begin
                route_wr.en       <= 1'b1;
                route_wr.out_port <= din.cfg.out_port[out_sel_bits-1:0];
                route_wr.leaf     <= din.cfg.route_leaf;
                route_wr.port     <= din.cfg.route_port;
            end

            for (int p = 0; p < `LEAF_NUM_IN_PORTS; p++) begin
                if (in_acks[p]) begin
                    in_words[p].vld <= 1'b0;
                end
                if (port_hit[p]) begin
                    if (port_full[p]) begin
                        // the tree cannot be stalled, so the packet is lost.
                        overflow <= 1'b1;
                    end else begin
                        in_words[p].vld  <= 1'b1;
                        in_words[p].data <= din.data.payload;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/leaf_pkg.sv
`default_nettype none

`include "leaf_settings.svh"

package leaf_pkg;

    // a configuration packet keeps dest_port at zero and carries a route in its body.
    localparam int cfg_reserved_bits = `LEAF_PACKET_BITS - 1 - 2 * `LEAF_NUM_LEAF_BITS
                                       - 3 * `LEAF_NUM_PORT_BITS;

    // out_port selects sum 1..3, so zero never names a lane.
    localparam int out_sel_bits = $clog2(`LEAF_NUM_OUT_PORTS + 1);

    typedef struct packed {
        logic                            valid;
        logic [`LEAF_NUM_LEAF_BITS-1:0]  dest_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0]  dest_port;
        logic [`LEAF_NUM_ADDR_BITS-1:0]  addr;
        logic [`LEAF_PAYLOAD_BITS-1:0]   payload;
    } bft_data_t;

    typedef struct packed {
        logic                            valid;
        logic [`LEAF_NUM_LEAF_BITS-1:0]  dest_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0]  dest_port;
        logic [`LEAF_NUM_PORT_BITS-1:0]  out_port;
        logic [`LEAF_NUM_LEAF_BITS-1:0]  route_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0]  route_port;
        logic [cfg_reserved_bits-1:0]    reserved;
    } bft_config_t;

    // the same flit read as data or as a routing update.
    typedef union packed {
        bft_data_t   data;
        bft_config_t cfg;
    } bft_packet_u;

    // one lane between stages, held until the receiver acks it.
    typedef struct packed {
        logic                          vld;
        logic [`LEAF_PAYLOAD_BITS-1:0] data;
    } port_word_t;

    // a single-cycle routing table write.
    typedef struct packed {
        logic                           en;
        logic [out_sel_bits-1:0]        out_port;
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0] port;
    } route_write_t;

endpackage

`default_nettype wire

//--- logic/leaf_settings.svh
`ifndef LEAF_SETTINGS_SVH
`define LEAF_SETTINGS_SVH

// a tree packet is one 49-bit flit.
`define LEAF_PACKET_BITS 49
`define LEAF_PAYLOAD_BITS 32

// address fields carried in every packet header.
`define LEAF_NUM_LEAF_BITS 5
`define LEAF_NUM_PORT_BITS 4
`define LEAF_NUM_ADDR_BITS 7

// port counts are fixed by the three adder lanes.
`define LEAF_NUM_IN_PORTS 7
`define LEAF_NUM_OUT_PORTS 3

`endif
